//--- flist.f
+incdir+.
tcb_pkg.sv
tcb_dec.sv
tcb_mem.sv
tcb_gpio.sv
tcb_mon.sv
tcb_top.sv
tcb_sva.sv
tcb_chk.sv
tcb_tb.sv

//--- tcb_tb.sv
`timescale 1ns/1ns
`include "tcb_defines.svh"

module tcb_tb;

  localparam int MAX_ENT = 32;

  logic           bus;
  logic           rst;
  logic           vld;
  logic           wen;
  tcb_pkg::ben_t  ben;
  tcb_pkg::adr_t  adr;
  tcb_pkg::dat_t  wdt;
  tcb_pkg::gpio_t gpio_in;
  logic           rdy;
  tcb_pkg::dat_t  rdt;
  tcb_pkg::gpio_t gpio_out;
  tcb_pkg::cnt_t  wr_cnt;
  tcb_pkg::cnt_t  rd_cnt;
  tcb_pkg::cnt_t  stall_cnt;
  logic           err;
  int             pass_cnt;
  int             fail_cnt;

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  logic           t_wen [0:MAX_ENT-1];
  tcb_pkg::ben_t  t_ben [0:MAX_ENT-1];
  tcb_pkg::adr_t  t_adr [0:MAX_ENT-1];
  tcb_pkg::dat_t  t_wdt [0:MAX_ENT-1];
  tcb_pkg::gpio_t t_gin [0:MAX_ENT-1];
  int             n_ent = 0;
  integer         seed = 49;

  // rnd set replaces the data with a random word
  task automatic add_entry(input logic w, input tcb_pkg::ben_t b, input tcb_pkg::adr_t a,
                           input tcb_pkg::dat_t d, input logic rnd, input tcb_pkg::gpio_t g);
    t_wen[n_ent] = w;
    t_ben[n_ent] = b;
    t_adr[n_ent] = a;
    t_wdt[n_ent] = rnd ? tcb_pkg::dat_t'($random(seed)) : d;
    t_gin[n_ent] = g;
    n_ent++;
  endtask

  task automatic build_table();
    // byte merge on one word
    add_entry(1'b1, 4'hf, 16'h0010, 32'h1122_3344, 1'b0, 8'h00);
    add_entry(1'b1, 4'h1, 16'h0010, '0, 1'b1, 8'h00);
    add_entry(1'b1, 4'h4, 16'h0010, '0, 1'b1, 8'h00);
    add_entry(1'b1, 4'hf, 16'h0014, '0, 1'b1, 8'h00);
    add_entry(1'b0, 4'hf, 16'h0010, '0, 1'b0, 8'h00);
    add_entry(1'b0, 4'hf, 16'h0014, '0, 1'b0, 8'h00);
    add_entry(1'b1, 4'ha, 16'h0010, '0, 1'b1, 8'h00);
    add_entry(1'b0, 4'h3, 16'h0010, '0, 1'b0, 8'h00);
    // gpio out register
    add_entry(1'b1, 4'h1, 16'h8000, '0, 1'b1, 8'h00);
    add_entry(1'b0, 4'hf, 16'h8000, '0, 1'b0, 8'h00);
    // pins settle over three memory writes before the in read
    add_entry(1'b1, 4'hf, 16'h0020, '0, 1'b1, 8'hc3);
    add_entry(1'b1, 4'hf, 16'h0024, '0, 1'b1, 8'hc3);
    add_entry(1'b1, 4'hf, 16'h0028, '0, 1'b1, 8'hc3);
    add_entry(1'b0, 4'hf, 16'h8004, '0, 1'b0, 8'hc3);
    add_entry(1'b0, 4'hf, 16'h8004, '0, 1'b0, 8'hc3);
    // ben bit 0 clear leaves gpio_out alone
    add_entry(1'b1, 4'h2, 16'h8000, '0, 1'b1, 8'hc3);
    add_entry(1'b0, 4'hf, 16'h8000, '0, 1'b0, 8'hc3);
    add_entry(1'b0, 4'hf, 16'h0020, '0, 1'b0, 8'hc3);
    // no byte enabled on a read, err from here on
    add_entry(1'b0, 4'h0, 16'h0024, '0, 1'b0, 8'hc3);
    add_entry(1'b0, 4'hf, 16'h0028, '0, 1'b0, 8'hc3);
    add_entry(1'b1, 4'h1, 16'h8000, '0, 1'b1, 8'hc3);
    add_entry(1'b0, 4'hf, 16'h8000, '0, 1'b0, 8'hc3);
  endtask

  ////////////////////////////////////////
  // dut, checker, assertions
  ////////////////////////////////////////

  tcb_top dut (
    .bus       (bus),
    .rst       (rst),
    .vld       (vld),
    .wen       (wen),
    .ben       (ben),
    .adr       (adr),
    .wdt       (wdt),
    .rdy       (rdy),
    .rdt       (rdt),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .wr_cnt    (wr_cnt),
    .rd_cnt    (rd_cnt),
    .stall_cnt (stall_cnt),
    .err       (err)
  );

  tcb_chk chk (
    .bus       (bus),
    .rst       (rst),
    .vld       (vld),
    .rdy       (rdy),
    .wen       (wen),
    .ben       (ben),
    .adr       (adr),
    .wdt       (wdt),
    .rdt       (rdt),
    .gpio_in   (gpio_in),
    .gpio_out  (gpio_out),
    .wr_cnt    (wr_cnt),
    .rd_cnt    (rd_cnt),
    .stall_cnt (stall_cnt),
    .err       (err),
    .pass_cnt  (pass_cnt),
    .fail_cnt  (fail_cnt)
  );

  bind tcb_top tcb_sva sva (
    .bus       (bus),
    .rst       (rst),
    .vld       (vld),
    .rdy       (rdy),
    .wen       (wen),
    .ben       (ben),
    .adr       (adr),
    .wdt       (wdt),
    .gpio_vld  (gpio_vld),
    .gpio_rdy  (gpio_rdy),
    .wr_cnt    (wr_cnt),
    .rd_cnt    (rd_cnt),
    .stall_cnt (stall_cnt),
    .err       (err)
  );

  // 20 ns clock
  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;
  end

  ////////////////////////////////////////
  // driver
  ////////////////////////////////////////

  initial begin : main
    int i;
    build_table();
    rst     = 1'b1;
    vld     = 1'b0;
    wen     = 1'b0;
    ben     = '0;
    adr     = '0;
    wdt     = '0;
    gpio_in = '0;
    repeat (10) @(posedge bus);
    #2;
    rst = 1'b0;
    for (i = 0; i < n_ent; i++) begin
      vld     = 1'b1;
      wen     = t_wen[i];
      ben     = t_ben[i];
      adr     = t_adr[i];
      wdt     = t_wdt[i];
      gpio_in = t_gin[i];
      // hold until rdy, transfer at the next rising edge
      @(negedge bus);
      while (!rdy) @(negedge bus);
      @(posedge bus);
      #2;
    end
    vld = 1'b0;
    wen = 1'b0;
    ben = '0;
    // let the checker see the last results
    repeat (3) @(posedge bus);
    $display("entries %0d, passed %0d, failed %0d, assertion failures %0d",
             n_ent, pass_cnt, fail_cnt, dut.sva.fail_cnt);
    if (fail_cnt == 0 && pass_cnt == n_ent && dut.sva.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog, four cycles per entry plus reset margin
  initial begin
    #1;
    repeat (n_ent * 4 + 50) @(posedge bus);
    $display("timeout, the driver did not finish the table in %0d cycles", n_ent * 4 + 50);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

//--- tcb_chk.sv
`timescale 1ns/1ns
`include "tcb_defines.svh"

module tcb_chk (
  input  logic           bus,
  input  logic           rst,
  // manager port as seen by the dut
  input  logic           vld,
  input  logic           rdy,
  input  logic           wen,
  input  tcb_pkg::ben_t  ben,
  input  tcb_pkg::adr_t  adr,
  input  tcb_pkg::dat_t  wdt,
  input  tcb_pkg::dat_t  rdt,
  // pins
  input  tcb_pkg::gpio_t gpio_in,
  input  tcb_pkg::gpio_t gpio_out,
  // monitor outputs
  input  tcb_pkg::cnt_t  wr_cnt,
  input  tcb_pkg::cnt_t  rd_cnt,
  input  tcb_pkg::cnt_t  stall_cnt,
  input  logic           err,
  // per entry results
  output int             pass_cnt,
  output int             fail_cnt
);

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  // sram as bytes, 4 per word
  logic [7:0]             mem_m [0:4*(2**`TCB_MEM_AW)-1];
  logic [`TCB_MEM_AW+1:0] bidx;
  logic [3:0]             ofs;
  tcb_pkg::gpio_t         exp_out;
  tcb_pkg::cnt_t          exp_wr;
  tcb_pkg::cnt_t          exp_rd;
  tcb_pkg::cnt_t          exp_stall;
  logic                   exp_err;
  tcb_pkg::dat_t          exp_rdt;
  // a transfer waits for its results
  logic                   pend = 1'b0;
  logic                   pend_rd;
  int                     ent = 0;
  int                     bad;

  initial begin
    pass_cnt = 0;
    fail_cnt = 0;
  end

  task automatic compare(input string what, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %0t ns: entry %0d %s is %h, expected %h", $time, ent, what, got, exp);
      bad = bad + 1;
    end
  endtask

  ////////////////////////////////////////
  // sample at the falling edge
  ////////////////////////////////////////

  always @(negedge bus) begin
    if (rst) begin
      exp_out   = '0;
      exp_wr    = '0;
      exp_rd    = '0;
      exp_stall = '0;
      exp_err   = 1'b0;
      pend      = 1'b0;
    end else begin
      // results of the transfer from the last rising edge
      if (pend) begin
        bad = 0;
        if (pend_rd) compare("rdt", rdt, exp_rdt);
        compare("gpio_out", gpio_out, exp_out);
        compare("wr_cnt", wr_cnt, exp_wr);
        compare("rd_cnt", rd_cnt, exp_rd);
        compare("stall_cnt", stall_cnt, exp_stall);
        compare("err", err, exp_err);
        if (bad == 0) begin
          pass_cnt++;
          $display("entry %0d ok", ent);
        end else begin
          fail_cnt++;
          $display("entry %0d had %0d mismatches", ent, bad);
        end
        pend = 1'b0;
        ent++;
      end
      // transfer at the next rising edge
      if (vld && rdy) begin
        ofs  = {adr[3:2], 2'b00};
        bidx = {adr[`TCB_MEM_AW+1:2], 2'b00};
        if (adr[`TCB_GPIO_BASE_BIT]) begin
          // every gpio transfer pays one stall
          exp_stall = exp_stall + 1'b1;
          if (wen && ben[0] && ofs == `TCB_GPIO_OUT_OFS) exp_out = wdt[`TCB_GPIO_W-1:0];
          if (ofs == `TCB_GPIO_OUT_OFS) exp_rdt = tcb_pkg::dat_t'(exp_out);
          else if (ofs == `TCB_GPIO_IN_OFS) exp_rdt = tcb_pkg::dat_t'(gpio_in);
          else exp_rdt = '0;
        end else begin
          // byte merge on write, whole word on read
          for (int i = 0; i < `TCB_BW; i++) begin
            if (wen && ben[i]) mem_m[bidx+i] = wdt[8*i +: 8];
            exp_rdt[8*i +: 8] = mem_m[bidx+i];
          end
        end
        if (wen) exp_wr = exp_wr + 1'b1;
        else exp_rd = exp_rd + 1'b1;
        // read with no byte enabled is a protocol error
        if (!wen && ben == '0) exp_err = 1'b1;
        pend_rd = !wen;
        pend    = 1'b1;
      end
    end
  end

endmodule

//--- tcb_sva.sv
`timescale 1ns/1ns
`include "tcb_defines.svh"

module tcb_sva (
  input logic          bus,
  input logic          rst,
  // manager port
  input logic          vld,
  input logic          rdy,
  input logic          wen,
  input tcb_pkg::ben_t ben,
  input tcb_pkg::adr_t adr,
  input tcb_pkg::dat_t wdt,
  // gpio handshake inside the top
  input logic          gpio_vld,
  input logic          gpio_rdy,
  // monitor outputs
  input tcb_pkg::cnt_t wr_cnt,
  input tcb_pkg::cnt_t rd_cnt,
  input tcb_pkg::cnt_t stall_cnt,
  input logic          err
);

  // number of failed assertions, read by the testbench
  int unsigned fail_cnt = 0;

  // stalled request held until rdy
  a_hold: assert property (@(posedge bus) disable iff (rst)
    vld && !rdy |=> vld && $stable(wen) && $stable(ben) && $stable(adr) && $stable(wdt))
  else begin
    fail_cnt++;
    $error("request changed while stalled");
  end

  // a gpio request not following a stall is in its first cycle
  a_gpio_wait: assert property (@(posedge bus) disable iff (rst)
    gpio_vld && !($past(gpio_vld) && !$past(gpio_rdy)) |-> !gpio_rdy)
  else begin
    fail_cnt++;
    $error("gpio rdy high in first request cycle");
  end

  // first cycle out of reset
  a_rst_val: assert property (@(posedge bus)
    !rst && $past(rst) |-> !err && !gpio_rdy && wr_cnt == '0 && rd_cnt == '0 && stall_cnt == '0)
  else begin
    fail_cnt++;
    $error("monitor or gpio not cleared by reset");
  end

endmodule

//--- tcb_top.sv
`timescale 1ns/1ns

module tcb_top (
  // clock and reset
  input  logic           bus,
  input  logic           rst,
  // manager port
  input  logic           vld,
  input  logic           wen,
  input  tcb_pkg::ben_t  ben,
  input  tcb_pkg::adr_t  adr,
  input  tcb_pkg::dat_t  wdt,
  output logic           rdy,
  output tcb_pkg::dat_t  rdt,
  // pins
  input  tcb_pkg::gpio_t gpio_in,
  output tcb_pkg::gpio_t gpio_out,
  // monitor outputs
  output tcb_pkg::cnt_t  wr_cnt,
  output tcb_pkg::cnt_t  rd_cnt,
  output tcb_pkg::cnt_t  stall_cnt,
  output logic           err
);

  ////////////////////////////////////////
  // decoder to subordinate wires
  ////////////////////////////////////////

  logic          mem_vld;
  logic          mem_rdy;
  tcb_pkg::dat_t mem_rdt;
  logic          gpio_vld;
  logic          gpio_rdy;
  tcb_pkg::dat_t gpio_rdt;

  // address decoder
  tcb_dec dec (
    .bus      (bus),
    .rst      (rst),
    .vld      (vld),
    .adr      (adr),
    .mem_vld  (mem_vld),
    .gpio_vld (gpio_vld),
    .rdy      (rdy),
    .rdt      (rdt),
    .mem_rdy  (mem_rdy),
    .gpio_rdy (gpio_rdy),
    .mem_rdt  (mem_rdt),
    .gpio_rdt (gpio_rdt)
  );

  // sram, request fields shared with gpio
  tcb_mem mem (
    .bus (bus),
    .vld (mem_vld),
    .wen (wen),
    .ben (ben),
    .adr (adr),
    .wdt (wdt),
    .rdy (mem_rdy),
    .rdt (mem_rdt)
  );

  // gpio registers
  tcb_gpio gpio (
    .bus      (bus),
    .rst      (rst),
    .vld      (gpio_vld),
    .wen      (wen),
    .ben      (ben),
    .adr      (adr),
    .wdt      (wdt),
    .gpio_in  (gpio_in),
    .rdy      (gpio_rdy),
    .rdt      (gpio_rdt),
    .gpio_out (gpio_out)
  );

  // passive monitor on the manager side
  tcb_mon mon (
    .bus       (bus),
    .rst       (rst),
    .vld       (vld),
    .rdy       (rdy),
    .wen       (wen),
    .ben       (ben),
    .adr       (adr),
    .wdt       (wdt),
    .wr_cnt    (wr_cnt),
    .rd_cnt    (rd_cnt),
    .stall_cnt (stall_cnt),
    .err       (err)
  );

endmodule

//--- tcb_mon.sv
`timescale 1ns/1ns

module tcb_mon (
  // clock and reset
  input  logic          bus,
  input  logic          rst,
  // observed manager port, all inputs
  input  logic          vld,
  input  logic          rdy,
  input  logic          wen,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::dat_t wdt,
  // statistics
  output tcb_pkg::cnt_t wr_cnt,
  output tcb_pkg::cnt_t rd_cnt,
  output tcb_pkg::cnt_t stall_cnt,
  // sticky protocol error
  output logic          err
);

  ////////////////////////////////////////
  // cycle classification
  ////////////////////////////////////////

  // transfer and stall in the current cycle
  logic trn;
  logic stall;

  assign trn   = vld & rdy;
  assign stall = vld & ~rdy;

  ////////////////////////////////////////
  // delayed request
  ////////////////////////////////////////

  // stalled in the previous cycle
  logic          dly_stall;
  // request fields from the previous cycle
  logic          dly_wen;
  tcb_pkg::ben_t dly_ben;
  tcb_pkg::adr_t dly_adr;
  tcb_pkg::dat_t dly_wdt;

  always_ff @(posedge bus) begin
    if (rst) begin
      dly_stall <= 1'b0;
    end else begin
      dly_stall <= stall;
    end
  end

  // fields only compared when dly_stall is set
  always_ff @(posedge bus) begin
    dly_wen <= wen;
    dly_ben <= ben;
    dly_adr <= adr;
    dly_wdt <= wdt;
  end

  ////////////////////////////////////////
  // protocol check
  ////////////////////////////////////////

  // stalled request must be held, dropping vld also counts
  logic chg_err;
  // read with no byte selected
  logic ben_err;

  assign chg_err = dly_stall & (~vld | (wen != dly_wen) | (ben != dly_ben) |
                                (adr != dly_adr) | (wdt != dly_wdt));
  assign ben_err = trn & ~wen & (ben == '0);

  // sticky until reset
  always_ff @(posedge bus) begin
    if (rst) begin
      err <= 1'b0;
    end else if (chg_err | ben_err) begin
      err <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // statistics
  ////////////////////////////////////////

  // free running, wrap on overflow
  always_ff @(posedge bus) begin
    if (rst) begin
      wr_cnt    <= '0;
      rd_cnt    <= '0;
      stall_cnt <= '0;
    end else begin
      if (trn & wen)  wr_cnt    <= wr_cnt + 1'b1;
      if (trn & ~wen) rd_cnt    <= rd_cnt + 1'b1;
      if (stall)      stall_cnt <= stall_cnt + 1'b1;
    end
  end

endmodule

//--- tcb_gpio.sv
`timescale 1ns/1ns
`include "tcb_defines.svh"

module tcb_gpio (
  // clock and reset
  input  logic            bus,
  input  logic            rst,
  // request
  input  logic            vld,
  input  logic            wen,
  input  tcb_pkg::ben_t   ben,
  input  tcb_pkg::adr_t   adr,
  input  tcb_pkg::dat_t   wdt,
  // asynchronous pins
  input  tcb_pkg::gpio_t  gpio_in,
  // response
  output logic            rdy,
  output tcb_pkg::dat_t   rdt,
  // driven pins
  output tcb_pkg::gpio_t  gpio_out
);

  ////////////////////////////////////////
  // wait-state FSM
  ////////////////////////////////////////

  tcb_pkg::gpio_st_t st;
  tcb_pkg::gpio_st_t st_nxt;

  // first vld cycle stalls, second one acks
  // always back to idle after the ack, so back-to-back requests stall again
  always_comb begin
    st_nxt = st;
    case (st)
      tcb_pkg::GPIO_IDLE: if (vld) st_nxt = tcb_pkg::GPIO_ACK;
      tcb_pkg::GPIO_ACK:  st_nxt = tcb_pkg::GPIO_IDLE;
      default:            st_nxt = tcb_pkg::GPIO_IDLE;
    endcase
  end

  always_ff @(posedge bus) begin
    if (rst) begin
      st <= tcb_pkg::GPIO_IDLE;
    end else begin
      st <= st_nxt;
    end
  end

  assign rdy = (st == tcb_pkg::GPIO_ACK);

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // transfer strobe
  logic           trn;
  // word aligned register offset
  logic [3:0]     ofs;
  // first synchronizer stage
  tcb_pkg::gpio_t in_meta;
  // second stage, this is the readable in register
  tcb_pkg::gpio_t in_q;

  assign trn = vld & rdy;
  assign ofs = {adr[3:2], 2'b00};

  // out register, only byte 0 of the write data counts
  always_ff @(posedge bus) begin
    if (rst) begin
      gpio_out <= '0;
    end else if (trn & wen & ben[0] & (ofs == `TCB_GPIO_OUT_OFS)) begin
      gpio_out <= wdt[`TCB_GPIO_W-1:0];
    end
  end

  // two flop synchronizer on the input pins
  always_ff @(posedge bus) begin
    in_meta <= gpio_in;
    in_q    <= in_meta;
  end

  // read data one cycle after the ack, zero extended
  // unmapped offsets read as zero
  always_ff @(posedge bus) begin
    if (trn & ~wen) begin
      case (ofs)
        `TCB_GPIO_OUT_OFS: rdt <= tcb_pkg::dat_t'(gpio_out);
        `TCB_GPIO_IN_OFS:  rdt <= tcb_pkg::dat_t'(in_q);
        default:           rdt <= '0;
      endcase
    end
  end

endmodule

//--- tcb_mem.sv
`timescale 1ns/1ns
`include "tcb_defines.svh"

module tcb_mem (
  // clock
  input  logic          bus,
  // request
  input  logic          vld,
  input  logic          wen,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rdy,
  output tcb_pkg::dat_t rdt
);

  // number of words in the array
  localparam int unsigned DEPTH = 2**`TCB_MEM_AW;

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  // word array
  tcb_pkg::dat_t mem [0:DEPTH-1];

  // word index, byte offset bits dropped
  logic [`TCB_MEM_AW-1:0] idx;

  assign idx = adr[`TCB_MEM_AW+1:2];

  // no wait states ever
  assign rdy = 1'b1;

  ////////////////////////////////////////
  // write port
  ////////////////////////////////////////

  // rdy is constant high, so vld alone marks a transfer
  // bytes with ben clear keep their old value
  always_ff @(posedge bus) begin
    if (vld & wen) begin
      for (int i = 0; i < `TCB_BW; i++) begin
        if (ben[i]) begin
          mem[idx][8*i +: 8] <= wdt[8*i +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////
  // read port
  ////////////////////////////////////////

  // full word registered at the read transfer edge
  // ben only matters for writes here
  // rdt holds its value until the next read
  always_ff @(posedge bus) begin
    if (vld & ~wen) begin
      rdt <= mem[idx];
    end
  end

endmodule

//--- tcb_dec.sv
`timescale 1ns/1ns
`include "tcb_defines.svh"

module tcb_dec (
  // clock and reset
  input  logic          bus,
  input  logic          rst,
  // manager request
  input  logic          vld,
  input  tcb_pkg::adr_t adr,
  // per subordinate valid
  output logic          mem_vld,
  output logic          gpio_vld,
  // response back to manager
  output logic          rdy,
  output tcb_pkg::dat_t rdt,
  // subordinate responses
  input  logic          mem_rdy,
  input  logic          gpio_rdy,
  input  tcb_pkg::dat_t mem_rdt,
  input  tcb_pkg::dat_t gpio_rdt
);

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  // target of the current request
  tcb_pkg::sel_t sel;
  // target of the last transfer, picks delayed rdt
  tcb_pkg::sel_t rd_sel;
  // transfer strobe on the manager side
  logic          trn;

  // single address bit splits the map in two halves
  assign sel = adr[`TCB_GPIO_BASE_BIT] ? tcb_pkg::SEL_GPIO : tcb_pkg::SEL_MEM;

  // vld reaches only the addressed subordinate
  assign mem_vld  = vld & (sel == tcb_pkg::SEL_MEM);
  assign gpio_vld = vld & (sel == tcb_pkg::SEL_GPIO);

  // handshake comes straight back from the target, no extra cycle
  assign rdy = (sel == tcb_pkg::SEL_GPIO) ? gpio_rdy : mem_rdy;

  assign trn = vld & rdy;

  ////////////////////////////////////////
  // read data return
  ////////////////////////////////////////

  // remember the target at every transfer
  // only reads look at it in the next cycle
  always_ff @(posedge bus) begin
    if (rst) begin
      rd_sel <= tcb_pkg::SEL_MEM;
    end else if (trn) begin
      rd_sel <= sel;
    end
  end

  // read latency is 1, so the mux uses the registered target
  // the current request may already point elsewhere
  assign rdt = (rd_sel == tcb_pkg::SEL_GPIO) ? gpio_rdt : mem_rdt;

endmodule

//--- tcb_pkg.sv
`include "tcb_defines.svh"

package tcb_pkg;

  ////////////////////////////////////////
  // bus field types
  ////////////////////////////////////////

  // byte address
  typedef logic [`TCB_AW-1:0] adr_t;
  // data word, both write and read direction
  typedef logic [`TCB_DW-1:0] dat_t;
  // byte enables
  typedef logic [`TCB_BW-1:0] ben_t;

  // gpio pin vector
  typedef logic [`TCB_GPIO_W-1:0] gpio_t;

  // monitor statistics counter
  typedef logic [`TCB_CNT_W-1:0] cnt_t;

  ////////////////////////////////////////
  // state encodings
  ////////////////////////////////////////

  // decoder target
  typedef enum logic {
    SEL_MEM,
    SEL_GPIO
  } sel_t;

  // gpio wait-state machine
  typedef enum logic {
    GPIO_IDLE,
    GPIO_ACK
  } gpio_st_t;

endpackage

//--- tcb_defines.svh
`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

////////////////////////////////////////
// bus geometry
////////////////////////////////////////

// byte address width
`define TCB_AW 16
// data word width
`define TCB_DW 32
// one enable per data byte
`define TCB_BW (`TCB_DW/8)

////////////////////////////////////////
// subordinates and statistics
////////////////////////////////////////

// sram holds 2**8 = 256 words
`define TCB_MEM_AW 8
// gpio pin count
`define TCB_GPIO_W 8
// statistics counters, wrap on overflow
`define TCB_CNT_W 16

////////////////////////////////////////
// address map
////////////////////////////////////////

// adr[15] set selects gpio, clear selects sram
`define TCB_GPIO_BASE_BIT 15
// register offsets inside the gpio block, low 4 address bits
`define TCB_GPIO_OUT_OFS 4'h0
`define TCB_GPIO_IN_OFS 4'h4

`endif
